// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - target: any(rtl, test)
    files:
      - logic/rv_isa_pkg.sv
      - logic/decode_pkg.sv
      - logic/inst_decoder.sv
      - logic/decode_out_reg.sv
      - logic/decode_stage.sv
  - target: test
    files:
      - testbench/decode_stage_sva.sv
      - testbench/tb_decode_stage.sv

// ==== flist.f ====
logic/rv_isa_pkg.sv
logic/decode_pkg.sv
logic/inst_decoder.sv
logic/decode_out_reg.sv
logic/decode_stage.sv
testbench/decode_stage_sva.sv
testbench/tb_decode_stage.sv

// ==== logic/decode_out_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_out_reg
    import decode_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                               i_clk,
    input  logic                               i_rst_n,

    input  logic                               i_valid,
    output logic                               o_ready,
    input  decode_bundle_t [ISSUE_WIDTH-1:0]   i_bundle,
    input  logic [$clog2(ISSUE_WIDTH)-1:0]     i_count,

    input  logic                               i_ready,
    output logic                               o_valid,
    output decode_bundle_t [ISSUE_WIDTH-1:0]   o_bundle,
    output logic [$clog2(ISSUE_WIDTH)-1:0]     o_count
);

    logic                             valid_q;
    decode_bundle_t [ISSUE_WIDTH-1:0] bundle_q;
    logic [$clog2(ISSUE_WIDTH)-1:0]   count_q;
    logic                             accept;

    // free when empty or draining this cycle
    assign o_ready = !valid_q || i_ready;
    assign accept  = i_valid && o_ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q  <= 1'b0;
            bundle_q <= '0;
            count_q  <= '0;
        end else begin
            if (accept) begin
                valid_q  <= 1'b1;
                bundle_q <= i_bundle;
                count_q  <= i_count;
            end else if (i_ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    assign o_valid  = valid_q;
    assign o_bundle = bundle_q;
    assign o_count  = count_q;

endmodule

`default_nettype wire

// ==== logic/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    import rv_isa_pkg::*;

    typedef enum logic {
        PIPE_XARITH = 1'b0,
        PIPE_XLOGIC = 1'b1
    } pipe_e;

    typedef enum logic {
        XARITH_ADD = 1'b0,
        XARITH_SLT = 1'b1
    } xarith_op_e;

    typedef enum logic [1:0] {
        XLOGIC_AND = 2'b00,
        XLOGIC_OR  = 2'b01,
        XLOGIC_XOR = 2'b10,
        XLOGIC_SHF = 2'b11
    } xlogic_op_e;

    // operand a select, rs1 by default
    typedef enum logic [1:0] {
        SRC_A_REG  = 2'b00,
        SRC_A_PC   = 2'b01,
        SRC_A_ZERO = 2'b10
    } src_a_e;

    typedef struct packed {
        xarith_op_e op;
        logic       sub;
        logic       unsigned_cmp;
        logic       word;
    } xarith_ctrl_t;

    typedef struct packed {
        xlogic_op_e op;
        logic       shift_right;
        logic       shift_arith;
        logic       word;
    } xlogic_ctrl_t;

    // one decoded slot
    typedef struct packed {
        logic         legal;
        reg_addr_t    rd;
        reg_addr_t    rs2;
        reg_addr_t    rs1;
        logic [31:0]  imm;
        pipe_e        pipe;
        src_a_e       src_a;
        logic         use_imm;
        xarith_ctrl_t xarith;
        xlogic_ctrl_t xlogic;
    } decode_bundle_t;

endpackage

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import rv_isa_pkg::*;
    import decode_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                               i_clk,
    input  logic                               i_rst_n,

    // upstream
    input  logic                               i_input_valid,
    output logic                               o_input_ready,
    input  inst_t [ISSUE_WIDTH-1:0]            i_inst,
    input  logic [$clog2(ISSUE_WIDTH)-1:0]     i_count,

    // downstream
    input  logic                               i_output_ready,
    output logic                               o_output_valid,
    output decode_bundle_t [ISSUE_WIDTH-1:0]   o_bundle,
    output logic [$clog2(ISSUE_WIDTH)-1:0]     o_count
);

    decode_bundle_t [ISSUE_WIDTH-1:0] slot_bundle;

    // one decoder per slot
    generate
        for (genvar slot = 0; slot < ISSUE_WIDTH; slot++) begin : g_slot
            inst_decoder inst_decoder_inst (
                .i_inst   (i_inst[slot]),
                .o_bundle (slot_bundle[slot])
            );
        end
    endgenerate

    decode_out_reg #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) decode_out_reg_inst (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_input_valid),
        .o_ready  (o_input_ready),
        .i_bundle (slot_bundle),
        .i_count  (i_count),
        .i_ready  (i_output_ready),
        .o_valid  (o_output_valid),
        .o_bundle (o_bundle),
        .o_count  (o_count)
    );

endmodule

`default_nettype wire

// ==== logic/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  inst_t          i_inst,
    output decode_bundle_t o_bundle
);

    opcode_t     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    // bits above the 6-bit shamt of slli/srli/srai
    logic [F7_HI-IMM_I_LO-SHAMT_W:0] funct6;
    logic        reg_op;
    logic        word_op;
    logic        funct7_ok;
    logic        word_f3_ok;
    logic        legal;
    logic [31:0] imm_i;
    logic [31:0] imm_u;

    assign opcode = opcode_t'(i_inst[OPCODE_HI:OPCODE_LO]);
    assign funct3 = i_inst[F3_HI:F3_LO];
    assign funct7 = i_inst[F7_HI:F7_LO];
    assign funct6 = i_inst[F7_HI:IMM_I_LO+SHAMT_W];

    assign reg_op  = (opcode == OP) || (opcode == OP_32);
    assign word_op = (opcode == OP_IMM_32) || (opcode == OP_32);

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:IMM_I_LO]};
    assign imm_u = {i_inst[31:IMM_U_LO], {IMM_U_LO{1'b0}}};

    // alt funct7 only for sub and sra forms
    assign funct7_ok = (funct7 == F7_BASE) ||
                       ((funct7 == F7_ALT) && ((funct3 == F3_ADD) || (funct3 == F3_SR)));

    // the -32 opcodes only have add, sll and sr
    assign word_f3_ok = (funct3 == F3_ADD) || (funct3 == F3_SLL) || (funct3 == F3_SR);

    always_comb begin
        legal = 1'b0;
        case (opcode)
            OP_IMM: begin
                case (funct3)
                    F3_SLL:  legal = (funct6 == F7_BASE[6:1]);
                    F3_SR:   legal = (funct6 == F7_BASE[6:1]) || (funct6 == F7_ALT[6:1]);
                    default: legal = 1'b1;
                endcase
            end
            // addiw has no funct7 field
            OP_IMM_32: legal = word_f3_ok && ((funct3 == F3_ADD) || funct7_ok);
            OP:        legal = funct7_ok;
            OP_32:     legal = word_f3_ok && funct7_ok;
            LUI,
            AUIPC:     legal = 1'b1;
            default:   legal = 1'b0;
        endcase
    end

    always_comb begin
        o_bundle       = '0;
        o_bundle.legal = legal;
        o_bundle.rd    = i_inst[RD_HI:RD_LO];
        o_bundle.rs1   = i_inst[RS1_HI:RS1_LO];
        o_bundle.rs2   = i_inst[RS2_HI:RS2_LO];
        o_bundle.src_a = SRC_A_REG;

        case (opcode)
            OP_IMM,
            OP_IMM_32,
            OP,
            OP_32: begin
                o_bundle.use_imm = !reg_op;
                if (!reg_op) begin
                    o_bundle.imm = imm_i;
                end

                case (funct3)
                    F3_ADD: begin
                        o_bundle.pipe       = PIPE_XARITH;
                        o_bundle.xarith.op  = XARITH_ADD;
                        o_bundle.xarith.sub = reg_op && (funct7 == F7_ALT);
                    end
                    F3_SLT,
                    F3_SLTU: begin
                        o_bundle.pipe       = PIPE_XARITH;
                        o_bundle.xarith.op  = XARITH_SLT;
                        // compare is done as a subtract
                        o_bundle.xarith.sub = 1'b1;
                    end
                    F3_XOR: begin
                        o_bundle.pipe      = PIPE_XLOGIC;
                        o_bundle.xlogic.op = XLOGIC_XOR;
                    end
                    F3_OR: begin
                        o_bundle.pipe      = PIPE_XLOGIC;
                        o_bundle.xlogic.op = XLOGIC_OR;
                    end
                    F3_AND: begin
                        o_bundle.pipe      = PIPE_XLOGIC;
                        o_bundle.xlogic.op = XLOGIC_AND;
                    end
                    F3_SLL,
                    F3_SR: begin
                        o_bundle.pipe               = PIPE_XLOGIC;
                        o_bundle.xlogic.op          = XLOGIC_SHF;
                        o_bundle.xlogic.shift_right = (funct3 == F3_SR);
                        o_bundle.xlogic.shift_arith = (funct3 == F3_SR) && i_inst[30];
                    end
                endcase

                // only the selected pipe gets its remaining fields
                if (o_bundle.pipe == PIPE_XARITH) begin
                    o_bundle.xarith.unsigned_cmp = funct3[0];
                    o_bundle.xarith.word         = word_op;
                end else begin
                    o_bundle.xlogic.word = word_op;
                end
            end
            LUI: begin
                o_bundle.imm       = imm_u;
                o_bundle.use_imm   = 1'b1;
                o_bundle.src_a     = SRC_A_ZERO;
                o_bundle.pipe      = PIPE_XARITH;
                o_bundle.xarith.op = XARITH_ADD;
            end
            AUIPC: begin
                o_bundle.imm       = imm_u;
                o_bundle.use_imm   = 1'b1;
                o_bundle.src_a     = SRC_A_PC;
                o_bundle.pipe      = PIPE_XARITH;
                o_bundle.xarith.op = XARITH_ADD;
            end
            default: begin
                // unsupported opcode, bundle stays zero apart from registers
                o_bundle.use_imm = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 64;
    // shift amount width on rv64
    localparam int SHAMT_W = $clog2(XLEN);

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // instruction field positions
    localparam int OPCODE_HI = 6;
    localparam int OPCODE_LO = 2;
    localparam int RD_HI     = 11;
    localparam int RD_LO     = 7;
    localparam int F3_HI     = 14;
    localparam int F3_LO     = 12;
    localparam int RS1_HI    = 19;
    localparam int RS1_LO    = 15;
    localparam int RS2_HI    = 24;
    localparam int RS2_LO    = 20;
    localparam int F7_HI     = 31;
    localparam int F7_LO     = 25;
    localparam int IMM_I_LO  = 20;
    localparam int IMM_U_LO  = 12;

    // major opcodes, bits 6..2
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        OP_IMM    = 5'b00100,
        AUIPC     = 5'b00101,
        OP_IMM_32 = 5'b00110,
        STORE     = 5'b01000,
        OP        = 5'b01100,
        LUI       = 5'b01101,
        OP_32     = 5'b01110,
        BRANCH    = 5'b11000
    } opcode_t;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    // srl and sra share one code
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    // sub and sra
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

// ==== testbench/decode_stage_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_sva
    import decode_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_valid,
    input  decode_bundle_t [ISSUE_WIDTH-1:0]   i_bundle,
    input  logic [$clog2(ISSUE_WIDTH)-1:0]     i_count,
    input  logic                               i_ready,
    input  logic                               o_ready,
    input  logic                               o_valid,
    input  decode_bundle_t [ISSUE_WIDTH-1:0]   o_bundle,
    input  logic [$clog2(ISSUE_WIDTH)-1:0]     o_count
);

    // register comes out of reset empty
    assert property (@(posedge i_clk) $rose(i_rst_n) |-> !o_valid)
        else $error("o_valid high in the first cycle after reset");

    // held payload under back-pressure
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_bundle) && $stable(o_count)))
        else $error("output changed while held by back-pressure");

    // accepted pair lands in the register one cycle later
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_valid && o_ready) |=> (o_valid && (o_bundle == $past(i_bundle)) &&
                                  (o_count == $past(i_count))))
        else $error("accepted payload missing from the register");

endmodule

bind decode_out_reg decode_stage_sva #(
    .ISSUE_WIDTH (ISSUE_WIDTH)
) decode_stage_sva_inst (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (i_valid),
    .i_bundle (i_bundle),
    .i_count  (i_count),
    .i_ready  (i_ready),
    .o_ready  (o_ready),
    .o_valid  (o_valid),
    .o_bundle (o_bundle),
    .o_count  (o_count)
);

`default_nettype wire

// ==== testbench/tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage
    import rv_isa_pkg::*;
    import decode_pkg::*;
;

    localparam int ISSUE_WIDTH    = 2;
    localparam int CNT_W          = $clog2(ISSUE_WIDTH);
    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_TRANSFERS  = 2000;
    localparam int TIMEOUT_CYCLES = 200;

    typedef struct packed {
        inst_t [ISSUE_WIDTH-1:0] inst;
        logic [CNT_W-1:0]        count;
    } pair_t;

    logic                             i_clk;
    logic                             i_rst_n;
    logic                             i_input_valid;
    logic                             o_input_ready;
    inst_t [ISSUE_WIDTH-1:0]          i_inst;
    logic [CNT_W-1:0]                 i_count;
    logic                             i_output_ready;
    logic                             o_output_valid;
    decode_bundle_t [ISSUE_WIDTH-1:0] o_bundle;
    logic [CNT_W-1:0]                 o_count;

    pair_t       pending[$];
    logic [31:0] lcg_state = 32'h007d_cf48;

    decode_stage #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) decode_stage_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_input_valid  (i_input_valid),
        .o_input_ready  (o_input_ready),
        .i_inst         (i_inst),
        .i_count        (i_count),
        .i_output_ready (i_output_ready),
        .o_output_valid (o_output_valid),
        .o_bundle       (o_bundle),
        .o_count        (o_count)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // weighted toward the decoded opcodes
    function automatic opcode_t pick_opcode(logic [3:0] sel);
        case (sel)
            4'd0, 4'd1, 4'd2: return OP_IMM;
            4'd3, 4'd4, 4'd5: return OP;
            4'd6, 4'd7:       return OP_IMM_32;
            4'd8, 4'd9:       return OP_32;
            4'd10:            return LUI;
            4'd11:            return AUIPC;
            4'd12:            return LOAD;
            4'd13:            return STORE;
            default:          return BRANCH;
        endcase
    endfunction

    function automatic inst_t random_inst();
        inst_t       inst;
        logic [31:0] r;
        inst = lcg_next();
        r    = lcg_next();
        // mostly valid funct7 patterns, some fully random
        case (r[22:21])
            2'd0:    inst[31:25] = F7_BASE;
            2'd1:    inst[31:25] = F7_ALT;
            2'd2:    inst[31:26] = F7_BASE[6:1];
            default: inst = inst;
        endcase
        inst[6:0] = {pick_opcode(r[19:16]), 2'b11};
        return inst;
    endfunction

    function automatic decode_bundle_t ref_decode(inst_t inst);
        decode_bundle_t b;
        logic [4:0]     opc;
        logic [2:0]     f3;
        logic [6:0]     f7;
        logic           alu;
        logic           is_reg;
        logic           is_word;
        b       = '0;
        opc     = inst[6:2];
        f3      = inst[14:12];
        f7      = inst[31:25];
        b.rd    = inst[11:7];
        b.rs1   = inst[19:15];
        b.rs2   = inst[24:20];
        is_reg  = (opc == OP) || (opc == OP_32);
        is_word = (opc == OP_IMM_32) || (opc == OP_32);
        alu     = is_reg || (opc == OP_IMM) || (opc == OP_IMM_32);
        case (opc)
            OP_IMM: begin
                b.imm = {{20{inst[31]}}, inst[31:20]};
                if (f3 == F3_SLL)
                    b.legal = (inst[31:26] == 6'b000000);
                else if (f3 == F3_SR)
                    b.legal = (inst[31:26] == 6'b000000) || (inst[31:26] == 6'b010000);
                else
                    b.legal = 1'b1;
            end
            OP_IMM_32: begin
                b.imm   = {{20{inst[31]}}, inst[31:20]};
                b.legal = (f3 == F3_ADD) || ((f3 == F3_SLL) && (f7 == F7_BASE)) ||
                          ((f3 == F3_SR) && ((f7 == F7_BASE) || (f7 == F7_ALT)));
            end
            OP, OP_32: begin
                b.legal = (f7 == F7_BASE) ||
                          ((f7 == F7_ALT) && ((f3 == F3_ADD) || (f3 == F3_SR)));
                if (opc == OP_32)
                    b.legal = b.legal && ((f3 == F3_ADD) || (f3 == F3_SLL) || (f3 == F3_SR));
            end
            LUI, AUIPC: begin
                b.imm     = {inst[31:12], 12'b0};
                b.legal   = 1'b1;
                b.use_imm = 1'b1;
                b.pipe    = PIPE_XARITH;
                b.src_a   = (opc == LUI) ? SRC_A_ZERO : SRC_A_PC;
            end
            default: b.legal = 1'b0;
        endcase
        if (alu) begin
            b.use_imm = !is_reg;
            if ((f3 == F3_ADD) || (f3 == F3_SLT) || (f3 == F3_SLTU)) begin
                b.pipe                = PIPE_XARITH;
                b.xarith.op           = (f3 == F3_ADD) ? XARITH_ADD : XARITH_SLT;
                b.xarith.sub          = (f3 != F3_ADD) || (is_reg && (f7 == F7_ALT));
                b.xarith.unsigned_cmp = f3[0];
                b.xarith.word         = is_word;
            end else begin
                b.pipe = PIPE_XLOGIC;
                case (f3)
                    F3_XOR:  b.xlogic.op = XLOGIC_XOR;
                    F3_OR:   b.xlogic.op = XLOGIC_OR;
                    F3_AND:  b.xlogic.op = XLOGIC_AND;
                    default: b.xlogic.op = XLOGIC_SHF;
                endcase
                b.xlogic.shift_right = (f3 == F3_SR);
                b.xlogic.shift_arith = (f3 == F3_SR) && inst[30];
                b.xlogic.word        = is_word;
            end
        end
        return b;
    endfunction

    task automatic check_value(string field, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, field, actual, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic compare_slot(int slot, decode_bundle_t got, decode_bundle_t exp);
        string tag;
        tag = $sformatf("slot %0d", slot);
        check_value({tag, " legal"}, got.legal, exp.legal);
        check_value({tag, " rd"}, got.rd, exp.rd);
        check_value({tag, " rs1"}, got.rs1, exp.rs1);
        check_value({tag, " rs2"}, got.rs2, exp.rs2);
        check_value({tag, " imm"}, got.imm, exp.imm);
        // the rest only carries meaning for legal slots
        if (exp.legal) begin
            check_value({tag, " pipe"}, got.pipe, exp.pipe);
            check_value({tag, " src_a"}, got.src_a, exp.src_a);
            check_value({tag, " use_imm"}, got.use_imm, exp.use_imm);
            check_value({tag, " xarith"}, got.xarith, exp.xarith);
            check_value({tag, " xlogic"}, got.xlogic, exp.xlogic);
        end
    endtask

    task automatic report_timeout(string what);
        $display("Timeout at %0t ns: %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
        $display("Finished with errors");
        $fatal(1, "timeout");
    endtask

    // scoreboard side
    always @(posedge i_clk) begin : compare
        pair_t sent;
        if (i_rst_n && o_output_valid && i_output_ready) begin
            if (pending.size() == 0) begin
                $display("Output transfer at %0t ns without any accepted input", $time);
                $display("Finished with errors");
                $fatal(1, "unexpected output");
            end else begin
                sent = pending.pop_front();
                check_value("count", o_count, sent.count);
                for (int s = 0; s < ISSUE_WIDTH; s++) begin
                    compare_slot(s, o_bundle[s], ref_decode(sent.inst[s]));
                end
            end
        end
    end

    initial begin : drive
        int    idle;
        int    out_seen;
        int    waited;
        pair_t accepted;
        i_rst_n        = 1'b0;
        i_input_valid  = 1'b0;
        i_inst         = '0;
        i_count        = '0;
        i_output_ready = 1'b0;
        idle           = 0;
        out_seen       = 0;
        waited         = 0;

        // register is cleared from the first reset edge on
        @(posedge i_clk);
        repeat (RESET_CYCLES - 1) begin
            @(posedge i_clk);
            check_value("o_output_valid in reset", o_output_valid, 1'b0);
            check_value("o_input_ready in reset", o_input_ready, 1'b1);
        end
        i_rst_n <= 1'b1;
        @(posedge i_clk);
        check_value("o_output_valid after reset", o_output_valid, 1'b0);
        check_value("o_input_ready after reset", o_input_ready, 1'b1);

        while (out_seen < NUM_TRANSFERS) begin
            @(posedge i_clk);
            if (o_output_valid && i_output_ready) begin
                out_seen++;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > TIMEOUT_CYCLES)
                report_timeout("no output transfer arrived");
            if (i_input_valid && o_input_ready) begin
                accepted.inst  = i_inst;
                accepted.count = i_count;
                pending.push_back(accepted);
            end
            // new payload only once the current one is taken
            if (!i_input_valid || o_input_ready) begin
                i_input_valid <= (lcg_next() % 4) != 0;
                for (int s = 0; s < ISSUE_WIDTH; s++) begin
                    i_inst[s] <= random_inst();
                end
                i_count <= lcg_next() >> 31;
            end
            i_output_ready <= (lcg_next() % 10) >= 3;
        end

        // drain whatever is still in the register
        i_input_valid  <= 1'b0;
        i_output_ready <= 1'b1;
        do begin
            @(posedge i_clk);
            waited++;
        end while (o_output_valid && (waited < TIMEOUT_CYCLES));
        if (o_output_valid)
            report_timeout("output register did not drain");

        if (pending.size() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("%0d accepted pairs never reached the output", pending.size());
            $display("Finished with errors");
            $fatal(1, "missing outputs");
        end
    end

endmodule

`default_nettype wire
